/* hw/MicroOpTypes.sv */
// Micro-op definitions shared by dispatch and the issue queue
// Import wherever a dispatched op or a physical register number is handled

package MicroOpTypes;

    typedef enum logic [1:0] {
        OP_INT     = 2'd0,
        OP_MEM     = 2'd1,
        OP_COMPLEX = 2'd2
    } OpType;

    typedef enum logic {MEM_LOAD = 1'b0, MEM_STORE = 1'b1} MemSubType;

    typedef enum logic {COMPLEX_MUL = 1'b0, COMPLEX_DIV = 1'b1} ComplexSubType;

    localparam int PHY_REG_WIDTH = 5;
    localparam int PHY_REG_NUM = 1 << PHY_REG_WIDTH;
    localparam int OP_TAG_WIDTH = 4;

    typedef logic [PHY_REG_WIDTH-1:0] PhyRegNum;
    typedef logic [OP_TAG_WIDTH-1:0] OpTag;

    typedef struct packed {
        OpType opType;
        // Read as MemSubType or ComplexSubType depending on opType
        logic subType;
        logic srcValidA;
        PhyRegNum srcRegA;
        logic srcValidB;
        PhyRegNum srcRegB;
        logic dstValid;
        PhyRegNum dstReg;
        OpTag opTag;
    } DispatchOp;

endpackage

/* hw/SchedulerTypes.sv */
// Issue queue definitions: lanes, class flags, issued ops and wakeup tags
// Import together with MicroOpTypes in the issue-stage modules

package SchedulerTypes;

    import MicroOpTypes::*;

    typedef enum logic [1:0] {
        LANE_INT     = 2'd0,
        LANE_COMPLEX = 2'd1,
        LANE_LOAD    = 2'd2,
        LANE_STORE   = 2'd3
    } IssueLane;

    localparam int LANE_NUM = 4;

    // Issued entry pointer, wide enough for a queue of up to 16 entries
    localparam int ENTRY_PTR_WIDTH = 4;
    typedef logic [ENTRY_PTR_WIDTH-1:0] EntryPtr;

    typedef struct packed {
        logic isInt;
        logic isComplex;
        logic isDiv;
        logic isLoad;
        logic isStore;
    } OpClass;

    typedef struct packed {
        logic valid;
        EntryPtr entryPtr;
        OpTag opTag;
        logic dstValid;
        PhyRegNum dstReg;
        logic isDiv;
    } IssuedOp;

    typedef struct packed {
        logic valid;
        PhyRegNum num;
    } WakeupTag;

endpackage

/* hw/OpClassifier.sv */
// Decodes a dispatched op into the class flags kept by the scheduler
// Purely combinational, sits on the dispatch path

`timescale 1ns/1ps

module OpClassifier
    import MicroOpTypes::*, SchedulerTypes::*;
(
    input  DispatchOp op,
    output OpClass    opClass
);

    always_comb begin
        opClass = '0;
        case (op.opType)
            OP_INT: begin
                opClass.isInt = 1'b1;
            end
            OP_MEM: begin
                if (MemSubType'(op.subType) == MEM_STORE) begin
                    opClass.isStore = 1'b1;
                end else begin
                    opClass.isLoad = 1'b1;
                end
            end
            OP_COMPLEX: begin
                // Mul and div share the complex lane
                opClass.isComplex = 1'b1;
                opClass.isDiv = (ComplexSubType'(op.subType) == COMPLEX_DIV);
            end
            default: begin
                opClass = '0;
            end
        endcase
    end

    // An unknown opType would leave the op without a lane
    always_comb begin
        assert ($onehot({opClass.isInt, opClass.isComplex, opClass.isLoad, opClass.isStore}))
            else $error("op without exactly one issue lane");
    end

endmodule

/* hw/Scheduler.sv */
// Per-entry state of the issue queue
// Tracks which entries wait for issue and which lane they belong to,
// and turns that into one request vector per lane

`timescale 1ns/1ps

module Scheduler
    import SchedulerTypes::*;
#(
    parameter int ENTRY_NUM = 8,
    localparam int PTR_WIDTH = $clog2(ENTRY_NUM)
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                write,
    input  logic [PTR_WIDTH-1:0]                writePtr,
    input  OpClass                              opClass,
    input  logic [ENTRY_NUM-1:0]                flushVector,
    input  logic [LANE_NUM-1:0][ENTRY_NUM-1:0]  grant,
    input  logic                                divFree,
    output logic [ENTRY_NUM-1:0]                notIssued,
    output logic [LANE_NUM-1:0][ENTRY_NUM-1:0]  request
);

    OpClass entryClass [ENTRY_NUM];

    logic [ENTRY_NUM-1:0] granted;
    logic [ENTRY_NUM-1:0] writeMask;
    logic [ENTRY_NUM-1:0] live;

    always_comb begin
        granted = '0;
        for (int l = 0; l < LANE_NUM; l++) begin
            granted |= grant[l];
        end
        writeMask = '0;
        if (write) begin
            writeMask[writePtr] = 1'b1;
        end
    end

    // A new dispatch wins over a flush of the same slot
    always_ff @(posedge clk) begin
        if (rst) begin
            notIssued <= '0;
        end else begin
            notIssued <= (notIssued & ~(granted | flushVector)) | writeMask;
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            entryClass[writePtr] <= opClass;
        end
    end

    // Entries being flushed this cycle must not be picked
    assign live = notIssued & ~flushVector;

    always_comb begin
        for (int i = 0; i < ENTRY_NUM; i++) begin
            request[LANE_INT][i] = live[i] && entryClass[i].isInt;
            // Only one divide may be in the divider at a time
            request[LANE_COMPLEX][i] = live[i] && entryClass[i].isComplex
                                       && (!entryClass[i].isDiv || divFree);
            request[LANE_LOAD][i] = live[i] && entryClass[i].isLoad;
            request[LANE_STORE][i] = live[i] && entryClass[i].isStore;
        end
    end

    // Dispatch side must only pick free entries
    assert property (@(posedge clk) disable iff (rst) write |-> !notIssued[writePtr])
        else $error("dispatch overwrote a waiting entry");

    // Select must stay inside what was requested
    assert property (@(posedge clk) disable iff (rst) (grant & ~request) == '0)
        else $error("grant to a non-requesting entry");

endmodule

/* hw/WakeupSelect.sv */
// Source readiness and select for the issue queue
// Holds the physical register ready table, per-entry source tags and payload,
// and picks the lowest ready entry on each lane

`timescale 1ns/1ps

module WakeupSelect
    import MicroOpTypes::*, SchedulerTypes::*;
#(
    parameter int ENTRY_NUM = 8,
    localparam int PTR_WIDTH = $clog2(ENTRY_NUM)
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                write,
    input  logic [PTR_WIDTH-1:0]                writePtr,
    input  DispatchOp                           op,
    input  logic [ENTRY_NUM-1:0]                notIssued,
    input  logic [LANE_NUM-1:0][ENTRY_NUM-1:0]  request,
    input  logic                                stall,
    input  WakeupTag                            wakeup,
    output logic [LANE_NUM-1:0][ENTRY_NUM-1:0]  grant,
    output IssuedOp                             grantedOp [LANE_NUM]
);

    typedef struct packed {
        PhyRegNum num;
        logic ready;
    } SrcState;

    typedef struct packed {
        OpTag opTag;
        logic dstValid;
        PhyRegNum dstReg;
        logic isDiv;
    } EntryInfo;

    logic [PHY_REG_NUM-1:0] phyReady;
    SrcState srcA [ENTRY_NUM];
    SrcState srcB [ENTRY_NUM];
    EntryInfo entryInfo [ENTRY_NUM];

    logic [ENTRY_NUM-1:0] entryReady;
    logic [LANE_NUM-1:0][ENTRY_NUM-1:0] candidate;

    // Same-cycle wakeup counts as ready
    function automatic SrcState newSrc(input logic valid, input PhyRegNum num,
                                       input logic [PHY_REG_NUM-1:0] readyTable,
                                       input WakeupTag wk);
        SrcState s;
        s.num = num;
        s.ready = !valid || readyTable[num] || (wk.valid && wk.num == num);
        return s;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            phyReady <= '1;
        end else begin
            if (wakeup.valid) begin
                phyReady[wakeup.num] <= 1'b1;
            end
            if (write && op.dstValid) begin
                phyReady[op.dstReg] <= 1'b0;
            end
        end
    end

    // Waiting entries match the wakeup tag and a new dispatch overrides its slot
    always_ff @(posedge clk) begin
        for (int i = 0; i < ENTRY_NUM; i++) begin
            if (notIssued[i] && wakeup.valid) begin
                if (srcA[i].num == wakeup.num) begin
                    srcA[i].ready <= 1'b1;
                end
                if (srcB[i].num == wakeup.num) begin
                    srcB[i].ready <= 1'b1;
                end
            end
        end
        if (write) begin
            srcA[writePtr] <= newSrc(op.srcValidA, op.srcRegA, phyReady, wakeup);
            srcB[writePtr] <= newSrc(op.srcValidB, op.srcRegB, phyReady, wakeup);
            entryInfo[writePtr].opTag <= op.opTag;
            entryInfo[writePtr].dstValid <= op.dstValid;
            entryInfo[writePtr].dstReg <= op.dstReg;
            entryInfo[writePtr].isDiv <= (op.opType == OP_COMPLEX)
                                         && (ComplexSubType'(op.subType) == COMPLEX_DIV);
        end
    end

    // Lowest-index pick per lane
    always_comb begin
        for (int i = 0; i < ENTRY_NUM; i++) begin
            entryReady[i] = srcA[i].ready && srcB[i].ready;
        end
        for (int l = 0; l < LANE_NUM; l++) begin
            candidate[l] = request[l] & entryReady;
            grant[l] = stall ? '0 : candidate[l] & (~candidate[l] + ENTRY_NUM'(1));
        end
    end

    always_comb begin
        for (int l = 0; l < LANE_NUM; l++) begin
            grantedOp[l] = '0;
            for (int i = 0; i < ENTRY_NUM; i++) begin
                if (grant[l][i]) begin
                    grantedOp[l].valid = 1'b1;
                    grantedOp[l].entryPtr = EntryPtr'(i);
                    grantedOp[l].opTag = entryInfo[i].opTag;
                    grantedOp[l].dstValid = entryInfo[i].dstValid;
                    grantedOp[l].dstReg = entryInfo[i].dstReg;
                    grantedOp[l].isDiv = entryInfo[i].isDiv;
                end
            end
        end
    end

    for (genvar l = 0; l < LANE_NUM; l++) begin : gGrantCheck
        assert property (@(posedge clk) disable iff (rst) $onehot0(grant[l]))
            else $error("more than one grant on lane %0d", l);
    end

endmodule

/* hw/IssueBroadcast.sv */
// Issue registers and result-tag broadcast
// Non-div destinations go out as soon as they issue, a divide's destination
// follows after the divider latency and takes priority on the shared tag

`timescale 1ns/1ps

module IssueBroadcast
    import MicroOpTypes::*, SchedulerTypes::*;
#(
    parameter int DIV_LATENCY = 6,
    localparam int CNT_WIDTH = $clog2(DIV_LATENCY + 1)
) (
    input  logic     clk,
    input  logic     rst,
    input  IssuedOp  grantedOp [LANE_NUM],
    output IssuedOp  issued [LANE_NUM],
    output WakeupTag wakeup,
    output logic     divFree
);

    logic divBusy;
    logic [CNT_WIDTH-1:0] divCount;
    WakeupTag divTag;
    logic divFire;

    // Destinations still to broadcast, one bit per physical register
    logic [PHY_REG_NUM-1:0] pendingMask;
    logic [PHY_REG_NUM-1:0] newMask;
    logic [PHY_REG_NUM-1:0] candMask;
    logic [PHY_REG_NUM-1:0] pickMask;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int l = 0; l < LANE_NUM; l++) begin
                issued[l] <= '0;
            end
            pendingMask <= '0;
            divBusy <= 1'b0;
            divCount <= '0;
        end else begin
            for (int l = 0; l < LANE_NUM; l++) begin
                issued[l] <= grantedOp[l];
            end
            pendingMask <= candMask & ~pickMask;
            if (grantedOp[LANE_COMPLEX].valid && grantedOp[LANE_COMPLEX].isDiv) begin
                divBusy <= 1'b1;
                divCount <= CNT_WIDTH'(DIV_LATENCY);
            end else if (divBusy) begin
                if (divCount == '0) begin
                    divBusy <= 1'b0;
                end else begin
                    divCount <= divCount - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grantedOp[LANE_COMPLEX].valid && grantedOp[LANE_COMPLEX].isDiv) begin
            divTag.valid <= grantedOp[LANE_COMPLEX].dstValid;
            divTag.num <= grantedOp[LANE_COMPLEX].dstReg;
        end
    end

    assign divFree = !divBusy;
    assign divFire = divBusy && (divCount == '0) && divTag.valid;

    always_comb begin
        newMask = '0;
        for (int l = 0; l < LANE_NUM; l++) begin
            if (issued[l].valid && issued[l].dstValid && !issued[l].isDiv) begin
                newMask[issued[l].dstReg] = 1'b1;
            end
        end
        candMask = pendingMask | newMask;
        // Div result owns the bus this cycle, the rest wait
        pickMask = divFire ? '0 : candMask & (~candMask + PHY_REG_NUM'(1));

        wakeup = '0;
        if (divFire) begin
            wakeup = divTag;
        end else begin
            for (int r = 0; r < PHY_REG_NUM; r++) begin
                if (pickMask[r]) begin
                    wakeup.valid = 1'b1;
                    wakeup.num = PhyRegNum'(r);
                end
            end
        end
    end

endmodule

/* hw/IssueQueueTop.sv */
// Issue stage top level
// One op is dispatched per cycle into a chosen entry, up to four ops leave
// per cycle on the int, complex, load and store lanes

`timescale 1ns/1ps

module IssueQueueTop
    import MicroOpTypes::*, SchedulerTypes::*;
#(
    parameter int ENTRY_NUM = 8,
    parameter int DIV_LATENCY = 6,
    localparam int PTR_WIDTH = $clog2(ENTRY_NUM)
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 write,
    input  logic [PTR_WIDTH-1:0] writePtr,
    input  DispatchOp            op,
    input  logic                 stall,
    input  logic [ENTRY_NUM-1:0] flushVector,
    output IssuedOp              issued [LANE_NUM],
    output WakeupTag             wakeup
);

    OpClass opClass;
    logic [ENTRY_NUM-1:0] notIssued;
    logic [LANE_NUM-1:0][ENTRY_NUM-1:0] request;
    logic [LANE_NUM-1:0][ENTRY_NUM-1:0] grant;
    IssuedOp grantedOp [LANE_NUM];
    logic divFree;

    OpClassifier classifier (
        .op      (op),
        .opClass (opClass)
    );

    Scheduler #(.ENTRY_NUM(ENTRY_NUM)) scheduler (
        .clk         (clk),
        .rst         (rst),
        .write       (write),
        .writePtr    (writePtr),
        .opClass     (opClass),
        .flushVector (flushVector),
        .grant       (grant),
        .divFree     (divFree),
        .notIssued   (notIssued),
        .request     (request)
    );

    WakeupSelect #(.ENTRY_NUM(ENTRY_NUM)) wakeupSelect (
        .clk       (clk),
        .rst       (rst),
        .write     (write),
        .writePtr  (writePtr),
        .op        (op),
        .notIssued (notIssued),
        .request   (request),
        .stall     (stall),
        .wakeup    (wakeup),
        .grant     (grant),
        .grantedOp (grantedOp)
    );

    IssueBroadcast #(.DIV_LATENCY(DIV_LATENCY)) broadcast (
        .clk       (clk),
        .rst       (rst),
        .grantedOp (grantedOp),
        .issued    (issued),
        .wakeup    (wakeup),
        .divFree   (divFree)
    );

endmodule

/* sim/IssueChecker.sv */
// Scoreboard for the issue queue testbench
// Compares per-lane issue order and cycles with the stim file, checks that
// dependents issue after their producer's wakeup and that divides are serialized

`timescale 1ns/1ps

module IssueChecker
    import MicroOpTypes::*, SchedulerTypes::*;
#(
    parameter int ENTRY_NUM = 8,
    parameter int DIV_LATENCY = 6,
    localparam int PTR_WIDTH = $clog2(ENTRY_NUM)
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 write,
    input  logic [PTR_WIDTH-1:0] writePtr,
    input  DispatchOp            op,
    input  logic                 stall,
    input  IssuedOp              issued [LANE_NUM],
    input  WakeupTag             wakeup,
    output int                   errorCount,
    output int                   missingCount
);

    localparam int REC_LEN = 11;
    localparam int MAX_EXP = 16;

    logic [7:0] stim [1024];
    logic [3:0] expTag [LANE_NUM][MAX_EXP];
    int expCycle [LANE_NUM][MAX_EXP];
    int expCnt [LANE_NUM];
    int expPos [LANE_NUM];

    // Producer tracking per physical register and consumer sources per opTag
    logic pend [PHY_REG_NUM];
    int lastWake [PHY_REG_NUM];
    logic depOn [16][2];
    PhyRegNum depReg [16][2];

    // What each opTag was dispatched with
    int dispCycle [16];
    int dispPtr [16];
    logic dispDiv [16];
    logic dispDstValid [16];
    PhyRegNum dispDst [16];

    int cycle;
    logic prevStall;
    logic divPending;
    int divDue;
    PhyRegNum divDst;

    function automatic int countMissing();
        int n;
        n = 0;
        for (int l = 0; l < LANE_NUM; l++) begin
            n += expCnt[l] - expPos[l];
        end
        return n;
    endfunction

    initial begin
        int rec;
        int lane;
        errorCount = 0;
        cycle = 0;
        prevStall = 1'b0;
        divPending = 1'b0;
        for (int l = 0; l < LANE_NUM; l++) begin
            expCnt[l] = 0;
            expPos[l] = 0;
        end
        for (int r = 0; r < PHY_REG_NUM; r++) begin
            pend[r] = 1'b0;
            lastWake[r] = -1;
        end
        for (int t = 0; t < 16; t++) begin
            depOn[t][0] = 1'b0;
            depOn[t][1] = 1'b0;
            dispPtr[t] = -1;
            dispDiv[t] = 1'b0;
            dispDstValid[t] = 1'b0;
        end
        $readmemh("sim/issueStim.txt", stim);
        rec = 0;
        while (stim[rec * REC_LEN] !== 8'hFF && rec < 90) begin
            if (stim[rec * REC_LEN] == 8'h01) begin
                lane = int'(stim[rec * REC_LEN + 1]);
                expTag[lane][expCnt[lane]] = stim[rec * REC_LEN + 2][3:0];
                expCycle[lane][expCnt[lane]] = int'(stim[rec * REC_LEN + 3]);
                expCnt[lane]++;
            end
            rec++;
        end
        missingCount = countMissing();
        if (missingCount == 0) begin
            $display("Stim file holds no expected issues");
            errorCount++;
        end
    end

    task automatic checkIssue(input int lane, input IssuedOp iop);
        int pos;
        pos = expPos[lane];
        if (prevStall) begin
            $display("FAIL %0t: lane %0d issued tag %h during stall", $time, lane, iop.opTag);
            errorCount++;
        end
        if (pos >= expCnt[lane]) begin
            $display("FAIL %0t: unexpected tag %h on lane %0d", $time, iop.opTag, lane);
            errorCount++;
        end else begin
            if (iop.opTag != expTag[lane][pos]) begin
                $display("FAIL %0t: lane %0d issued tag %h, expected %h",
                         $time, lane, iop.opTag, expTag[lane][pos]);
                errorCount++;
            end else if (expCycle[lane][pos] != 0 && expCycle[lane][pos] != cycle) begin
                $display("FAIL %0t: tag %h issued in cycle %0d, expected %0d",
                         $time, iop.opTag, cycle, expCycle[lane][pos]);
                errorCount++;
            end
            expPos[lane]++;
        end
        if (iop.entryPtr != EntryPtr'(dispPtr[iop.opTag])) begin
            $display("FAIL %0t: tag %h issued from entry %0d, expected %0d",
                     $time, iop.opTag, iop.entryPtr, dispPtr[iop.opTag]);
            errorCount++;
        end
        if (iop.dstValid != dispDstValid[iop.opTag]
            || (iop.dstValid && iop.dstReg != dispDst[iop.opTag])) begin
            $display("FAIL %0t: tag %h issued with a wrong destination", $time, iop.opTag);
            errorCount++;
        end
        if (iop.isDiv != dispDiv[iop.opTag]) begin
            $display("FAIL %0t: tag %h issued with a wrong div flag", $time, iop.opTag);
            errorCount++;
        end
        // Source wakeup must come after dispatch and before the grant cycle
        for (int s = 0; s < 2; s++) begin
            if (depOn[iop.opTag][s]) begin
                if (lastWake[depReg[iop.opTag][s]] <= dispCycle[iop.opTag]
                    || lastWake[depReg[iop.opTag][s]] >= cycle - 1) begin
                    $display("FAIL %0t: tag %h issued without wakeup of register %0d",
                             $time, iop.opTag, depReg[iop.opTag][s]);
                    errorCount++;
                end
            end
        end
        if (dispDiv[iop.opTag]) begin
            if (divPending) begin
                $display("FAIL %0t: div tag %h issued while divider busy", $time, iop.opTag);
                errorCount++;
            end
            divPending = dispDstValid[iop.opTag];
            divDue = cycle + DIV_LATENCY;
            divDst = dispDst[iop.opTag];
        end
    endtask

    always @(negedge clk) begin
        if (rst) begin
            cycle = 0;
        end else begin
            if (divPending && cycle == divDue) begin
                if (!(wakeup.valid && wakeup.num == divDst)) begin
                    $display("FAIL %0t: div wakeup of register %0d missing", $time, divDst);
                    errorCount++;
                end
                divPending = 1'b0;
            end
            if (wakeup.valid) begin
                lastWake[wakeup.num] = cycle;
                pend[wakeup.num] = 1'b0;
            end
            for (int l = 0; l < LANE_NUM; l++) begin
                if (issued[l].valid) begin
                    checkIssue(l, issued[l]);
                end
            end
            if (write) begin
                dispCycle[op.opTag] = cycle;
                dispPtr[op.opTag] = int'(writePtr);
                dispDiv[op.opTag] = (op.opType == OP_COMPLEX)
                                    && (ComplexSubType'(op.subType) == COMPLEX_DIV);
                dispDstValid[op.opTag] = op.dstValid;
                dispDst[op.opTag] = op.dstReg;
                depOn[op.opTag][0] = op.srcValidA && pend[op.srcRegA];
                depReg[op.opTag][0] = op.srcRegA;
                depOn[op.opTag][1] = op.srcValidB && pend[op.srcRegB];
                depReg[op.opTag][1] = op.srcRegB;
                if (op.dstValid) begin
                    pend[op.dstReg] = 1'b1;
                end
            end
            prevStall = stall;
            missingCount = countMissing();
            cycle++;
        end
    end

endmodule

/* sim/IssueQueueTb.sv */
// Testbench top for the issue queue
// Replays dispatch, stall and flush commands from the stim file one per cycle,
// then waits for the checker to see every expected issue

`timescale 1ns/1ps

module IssueQueueTb
    import MicroOpTypes::*, SchedulerTypes::*;
;

    localparam int ENTRY_NUM = 8;
    localparam int DIV_LATENCY = 6;
    localparam int REC_LEN = 11;

    logic clk;
    logic rst;
    logic write;
    logic [$clog2(ENTRY_NUM)-1:0] writePtr;
    DispatchOp op;
    logic stall;
    logic [ENTRY_NUM-1:0] flushVector;
    IssuedOp issued [LANE_NUM];
    WakeupTag wakeup;

    logic [7:0] stim [1024];
    int errorCount;
    int missingCount;
    int cycleLimit;
    logic limitReady;
    logic finished;

    IssueQueueTop #(.ENTRY_NUM(ENTRY_NUM), .DIV_LATENCY(DIV_LATENCY)) dut (
        .clk         (clk),
        .rst         (rst),
        .write       (write),
        .writePtr    (writePtr),
        .op          (op),
        .stall       (stall),
        .flushVector (flushVector),
        .issued      (issued),
        .wakeup      (wakeup)
    );

    IssueChecker #(.ENTRY_NUM(ENTRY_NUM), .DIV_LATENCY(DIV_LATENCY)) scoreboard (
        .clk          (clk),
        .rst          (rst),
        .write        (write),
        .writePtr     (writePtr),
        .op           (op),
        .stall        (stall),
        .issued       (issued),
        .wakeup       (wakeup),
        .errorCount   (errorCount),
        .missingCount (missingCount)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // Register byte FF or above 1F means the operand is absent
    function automatic DispatchOp buildOp(input int base);
        DispatchOp d;
        d.opType = OpType'(stim[base + 5][1:0]);
        d.subType = stim[base + 6][0];
        d.srcValidA = stim[base + 7] < 8'h20;
        d.srcRegA = stim[base + 7][4:0];
        d.srcValidB = stim[base + 8] < 8'h20;
        d.srcRegB = stim[base + 8][4:0];
        d.dstValid = stim[base + 9] < 8'h20;
        d.dstReg = stim[base + 9][4:0];
        d.opTag = stim[base + 10][3:0];
        return d;
    endfunction

    initial begin
        int rec;
        int cmdCount;
        int divCount;
        rst = 1'b1;
        write = 1'b0;
        writePtr = '0;
        op = '0;
        stall = 1'b0;
        flushVector = '0;
        finished = 1'b0;
        limitReady = 1'b0;
        $readmemh("sim/issueStim.txt", stim);

        cmdCount = 0;
        divCount = 0;
        rec = 0;
        while (stim[rec * REC_LEN] !== 8'hFF && rec < 90) begin
            if (stim[rec * REC_LEN] == 8'h00) begin
                cmdCount++;
                if (stim[rec * REC_LEN + 1][0] && stim[rec * REC_LEN + 5] == 8'h02
                    && stim[rec * REC_LEN + 6] == 8'h01) begin
                    divCount++;
                end
            end
            rec++;
        end
        cycleLimit = cmdCount + DIV_LATENCY * divCount + 50;
        limitReady = 1'b1;

        repeat (15) @(posedge clk);
        rec = 0;
        while (stim[rec * REC_LEN] !== 8'hFF && rec < 90) begin
            if (stim[rec * REC_LEN] == 8'h00) begin
                @(posedge clk);
                #5;
                rst = 1'b0;
                write = stim[rec * REC_LEN + 1][0];
                writePtr = stim[rec * REC_LEN + 2][$clog2(ENTRY_NUM)-1:0];
                stall = stim[rec * REC_LEN + 3][0];
                flushVector = stim[rec * REC_LEN + 4];
                op = buildOp(rec * REC_LEN);
            end
            rec++;
        end
        @(posedge clk);
        #5;
        write = 1'b0;
        stall = 1'b0;
        flushVector = '0;

        wait (missingCount == 0);
        // A few idle cycles catch any extra issue
        repeat (10) @(posedge clk);
        finished = 1'b1;
        $display("Checks done: %0d errors, %0d expected issues missing",
                 errorCount, missingCount);
        if (errorCount == 0 && missingCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog covering reset, the command stream and the divider latency
    initial begin
        wait (limitReady);
        repeat (16 + cycleLimit) @(posedge clk);
        if (!finished) begin
            $display("Timeout: expected issues still missing after %0d cycles", cycleLimit);
            $display("Checks done: %0d errors, %0d expected issues missing",
                     errorCount, missingCount);
            $display("Simulation failed");
            $finish;
        end
    end

endmodule

/* sources.f */
hw/MicroOpTypes.sv
hw/SchedulerTypes.sv
hw/OpClassifier.sv
hw/Scheduler.sv
hw/WakeupSelect.sv
hw/IssueBroadcast.sv
hw/IssueQueueTop.sv
sim/IssueChecker.sv
sim/IssueQueueTb.sv

/* run.sh */
#!/bin/sh
# Build and run the issue queue testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module IssueQueueTb -Mdir obj_dir -o simIssueQueue
./obj_dir/simIssueQueue | tee sim.log
if grep -q "Simulation completed successfully" sim.log; then
    exit 0
fi
exit 1

/* sim/issueStim.txt */
// Record of 11 hex bytes. Command: 00 write ptr stall flush opType sub srcA srcB dst tag
// Expected issue: 01 lane tag cycle 00 00 00 00 00 00 00, register FF means none, FF ends
00 01 00 00 00 00 00 FF FF 01 01
00 01 01 00 00 01 00 03 FF 02 02
00 01 02 00 00 01 01 02 FF FF 03
00 01 03 00 00 02 00 01 FF 04 04
00 01 04 00 00 02 01 FF FF 05 05
00 01 05 00 00 02 01 FF FF 06 06
00 01 06 00 00 00 00 05 FF 07 07
00 01 07 00 00 00 00 FF FF 08 08
00 01 00 00 00 00 00 FF FF 09 09
00 01 01 01 00 00 00 FF FF 0A 0A
00 01 02 01 00 01 00 FF FF 0B 0B
00 00 00 01 00 00 00 FF FF FF 00
00 00 00 00 00 00 00 FF FF FF 00
00 01 02 00 00 01 00 06 FF 0C 0C
00 01 03 00 04 01 01 06 08 FF 0D
00 01 04 00 00 00 00 07 FF 0E 0E
00 00 00 00 00 00 00 FF FF FF 00
01 00 01 02 00 00 00 00 00 00 00
01 00 08 09 00 00 00 00 00 00 00
01 00 09 0D 00 00 00 00 00 00 00
01 00 0A 0E 00 00 00 00 00 00 00
01 00 07 0F 00 00 00 00 00 00 00
01 00 0E 11 00 00 00 00 00 00 00
01 01 04 05 00 00 00 00 00 00 00
01 01 05 06 00 00 00 00 00 00 00
01 01 06 0E 00 00 00 00 00 00 00
01 02 02 03 00 00 00 00 00 00 00
01 02 0B 0D 00 00 00 00 00 00 00
01 03 03 05 00 00 00 00 00 00 00
01 03 0D 16 00 00 00 00 00 00 00
FF 00 00 00 00 00 00 00 00 00 00
